//--- Bender.yml
package:
  name: commit_path

sources:
  - files:
      - common/robPkg.sv
      - hdl/ringBuffCtrl.sv
      - reorderBuff/reorderBuff.sv
      - hdl/issueDecoder.sv
      - hdl/execPipe.sv
      - hdl/commitTop.sv
  - target: simulation
    files:
      - verif/commitTb.sv

//--- common/robPkg.sv
package robPkg;

	////////////////////////////////////////
	// Widths that carry a meaning
	////////////////////////////////////////

	typedef logic [5:0]  issueNoT;	// Wraps mod 64, wider than any buffer depth
	typedef logic [15:0] dataT;
	typedef logic [1:0]  opcodeT;

	// Instruction kinds
	localparam opcodeT opAdd   = 2'd0;
	localparam opcodeT opSub   = 2'd1;
	localparam opcodeT opLoad  = 2'd2;	// Base plus offset on pipe 1
	localparam opcodeT opStore = 2'd3;	// Base plus offset on pipe 2

	////////////////////////////////////////
	// Records passed between blocks
	////////////////////////////////////////

	typedef struct packed {
		opcodeT opcode;
		dataT   opA;
		dataT   opB;
	} instrS;

	// Request into one execution pipe
	typedef struct packed {
		issueNoT issueNo;
		logic    sub;		// Subtract instead of add
		dataT    opA;
		dataT    opB;
	} execReqS;

	typedef struct packed {
		issueNoT issueNo;
		dataT    result;
	} completionS;

	// Head entry offered to the hazard unit
	typedef struct packed {
		issueNoT issueNo;
		dataT    result;
	} commitS;

endpackage

//--- flist.f
common/robPkg.sv
hdl/ringBuffCtrl.sv
reorderBuff/reorderBuff.sv
hdl/issueDecoder.sv
hdl/execPipe.sv
hdl/commitTop.sv
verif/commitTb.sv

//--- hdl/commitTop.sv
module commitTop #(
	parameter int numEntry    = 16,
	parameter int mathLatency = 4,
	parameter int ldstLatency = 2
)(
	input  logic           clock,
	input  logic           reset,
	input  logic           instrValid,
	input  robPkg::instrS  instr,
	output logic           instrStall,
	input  logic           commitGrant,
	output logic           commitReq,
	output robPkg::commitS commit,
	output logic           full,
	output logic           empty
);

	logic               store;
	robPkg::issueNoT    storeNo;
	logic               reqLdst1;
	logic               reqLdst2;
	logic               reqMath;
	robPkg::execReqS    req;	// Shared by the three pipes
	logic               doneLdst1;
	logic               doneLdst2;
	logic               doneMath;
	robPkg::completionS resLdst1;
	robPkg::completionS resLdst2;
	robPkg::completionS resMath;

	////////////////////////////////////////
	// Decode
	////////////////////////////////////////

	issueDecoder issueDec (
		.clock (clock), .reset (reset),
		.instrValid (instrValid), .instr (instr), .full (full),
		.instrStall (instrStall), .store (store), .storeNo (storeNo),
		.reqLdst1 (reqLdst1), .reqLdst2 (reqLdst2), .reqMath (reqMath),
		.req (req)
	);

	////////////////////////////////////////
	// Execute
	////////////////////////////////////////

	execPipe #(.latency (ldstLatency)) ldst1Pipe (
		.clock (clock), .reset (reset), .reqValid (reqLdst1), .req (req),
		.doneValid (doneLdst1), .done (resLdst1)
	);

	execPipe #(.latency (ldstLatency)) ldst2Pipe (
		.clock (clock), .reset (reset), .reqValid (reqLdst2), .req (req),
		.doneValid (doneLdst2), .done (resLdst2)
	);

	execPipe #(.latency (mathLatency)) mathPipe (	// Slowest pipe
		.clock (clock), .reset (reset), .reqValid (reqMath), .req (req),
		.doneValid (doneMath), .done (resMath)
	);

	// Result ordering
	reorderBuff #(.numEntry (numEntry)) rob (
		.clock (clock), .reset (reset), .store (store), .storeNo (storeNo),
		.doneLdst1 (doneLdst1), .doneLdst2 (doneLdst2), .doneMath (doneMath),
		.resLdst1 (resLdst1), .resLdst2 (resLdst2), .resMath (resMath),
		.commitGrant (commitGrant), .commitReq (commitReq), .commit (commit),
		.full (full), .empty (empty)
	);

endmodule

//--- hdl/execPipe.sv
module execPipe #(
	parameter int latency = 4
)(
	input  logic               clock,
	input  logic               reset,
	input  logic               reqValid,
	input  robPkg::execReqS    req,
	output logic               doneValid,
	output robPkg::completionS done
);

	robPkg::dataT       result;
	logic [latency-1:0] validSr;
	robPkg::completionS dataSr [latency];

	// Arithmetic happens before the first stage
	always_comb begin
		if (req.sub) begin
			result = req.opA - req.opB;
		end else begin
			result = req.opA + req.opB;	// Truncated to 16 bits
		end
	end

	////////////////////////////////////////
	// Delay line, one op per stage
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			validSr <= '0;
		end else begin
			validSr[0] <= reqValid;
			for (int k = 1; k < latency; k++) begin
				validSr[k] <= validSr[k-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		dataSr[0] <= '{issueNo: req.issueNo, result: result};
		for (int k = 1; k < latency; k++) begin
			dataSr[k] <= dataSr[k-1];
		end
	end

	assign doneValid = validSr[latency-1];
	assign done      = dataSr[latency-1];

	// A zero-deep pipe has no stage to hold the result
	minLatency: assert property (
		@(posedge clock) latency >= 1
	);

endmodule

//--- hdl/issueDecoder.sv
module issueDecoder (
	input  logic            clock,
	input  logic            reset,
	input  logic            instrValid,
	input  robPkg::instrS   instr,
	input  logic            full,
	output logic            instrStall,
	output logic            store,
	output robPkg::issueNoT storeNo,
	output logic            reqLdst1,
	output logic            reqLdst2,
	output logic            reqMath,
	output robPkg::execReqS req
);

	logic            accept;
	logic            sub;
	logic            selLdst1;
	logic            selLdst2;
	logic            selMath;
	robPkg::issueNoT issueCount;	// Next issue number

	assign accept     = instrValid & ~full;
	assign instrStall = full;	// Source holds its instruction meanwhile

	// Reserve the buffer slot on the accepting edge
	assign store   = accept;
	assign storeNo = issueCount;

	////////////////////////////////////////
	// Opcode to pipe steering
	////////////////////////////////////////

	always_comb begin
		sub      = 1'b0;
		selLdst1 = 1'b0;
		selLdst2 = 1'b0;
		selMath  = 1'b0;
		case (instr.opcode)
			robPkg::opAdd: selMath = 1'b1;
			robPkg::opSub: begin
				selMath = 1'b1;
				sub     = 1'b1;
			end
			robPkg::opLoad:  selLdst1 = 1'b1;	// Address is base plus offset
			robPkg::opStore: selLdst2 = 1'b1;
			default: selMath = 1'b1;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			issueCount <= '0;
			reqLdst1   <= 1'b0;
			reqLdst2   <= 1'b0;
			reqMath    <= 1'b0;
		end else begin
			if (accept) begin
				issueCount <= issueCount + 1'b1;	// Wraps past 63
			end
			reqLdst1 <= accept & selLdst1;
			reqLdst2 <= accept & selLdst2;
			reqMath  <= accept & selMath;
		end
	end

	// One request record, shared by all pipes
	always_ff @(posedge clock) begin
		if (accept) begin
			req <= '{issueNo: issueCount, sub: sub, opA: instr.opA, opB: instr.opB};
		end
	end

endmodule

//--- hdl/ringBuffCtrl.sv
module ringBuffCtrl #(
	parameter int numEntry = 16,
	localparam int addrWidth = $clog2(numEntry)
)(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 write,
	input  logic                 read,
	output logic [addrWidth-1:0] writeAddr,
	output logic [addrWidth-1:0] readAddr,
	output logic                 full,
	output logic                 empty
);

	localparam int countWidth = $clog2(numEntry + 1);

	logic [countWidth-1:0] count;	// Entries in use

	// Pointers wrap at the depth, which need not be a power of two
	always_ff @(posedge clock) begin
		if (reset) begin
			writeAddr <= '0;
			readAddr  <= '0;
			count     <= '0;
		end else begin
			if (write) begin
				writeAddr <= (writeAddr == addrWidth'(numEntry - 1)) ? '0 : writeAddr + 1'b1;
			end
			if (read) begin
				readAddr <= (readAddr == addrWidth'(numEntry - 1)) ? '0 : readAddr + 1'b1;
			end
			case ({write, read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Both or neither
			endcase
		end
	end

	assign full  = (count == countWidth'(numEntry));
	assign empty = (count == '0);

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Decoder must stall before the ring overflows
	noWriteWhenFull: assert property (
		@(posedge clock) disable iff (reset) write |-> !full
	);

	// Commit only ever offered for a stored entry
	noReadWhenEmpty: assert property (
		@(posedge clock) disable iff (reset) read |-> !empty
	);

endmodule

//--- reorderBuff/reorderBuff.sv
module reorderBuff #(
	parameter int numEntry = 16
)(
	input  logic                clock,
	input  logic                reset,
	input  logic                store,
	input  robPkg::issueNoT     storeNo,
	input  logic                doneLdst1,
	input  logic                doneLdst2,
	input  logic                doneMath,
	input  robPkg::completionS  resLdst1,
	input  robPkg::completionS  resLdst2,
	input  robPkg::completionS  resMath,
	input  logic                commitGrant,
	output logic                commitReq,
	output robPkg::commitS      commit,
	output logic                full,
	output logic                empty
);

	localparam int addrWidth = $clog2(numEntry);
	localparam int numPipe   = 3;

	typedef struct packed {
		logic            valid;
		logic            done;
		robPkg::issueNoT issueNo;
		robPkg::dataT    result;
	} entryS;

	entryS entries [numEntry];

	logic                 write;
	logic                 read;
	logic [addrWidth-1:0] writeAddr;
	logic [addrWidth-1:0] readAddr;

	logic [numPipe-1:0]  doneIn;
	robPkg::completionS  resIn [numPipe];
	logic [numPipe-1:0]  compValid;	// Completions latched for one cycle
	robPkg::completionS  comp [numPipe];
	logic [numEntry-1:0] hit [numPipe];	// Per pipe, which entry it finishes

	// Pipe order: ldst1, ldst2, math
	assign doneIn   = {doneMath, doneLdst2, doneLdst1};
	assign resIn[0] = resLdst1;
	assign resIn[1] = resLdst2;
	assign resIn[2] = resMath;

	////////////////////////////////////////
	// Completion capture
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			compValid <= '0;
		end else begin
			compValid <= doneIn;
		end
	end

	always_ff @(posedge clock) begin
		for (int p = 0; p < numPipe; p++) begin
			comp[p] <= resIn[p];
		end
	end

	// Match each latched completion against the live entries
	always_comb begin
		for (int p = 0; p < numPipe; p++) begin
			for (int i = 0; i < numEntry; i++) begin
				hit[p][i] = compValid[p] & entries[i].valid &
					(entries[i].issueNo == comp[p].issueNo);
			end
		end
	end

	////////////////////////////////////////
	// Entry table
	////////////////////////////////////////

	assign commitReq = entries[readAddr].valid & entries[readAddr].done;
	assign commit    = '{issueNo: entries[readAddr].issueNo, result: entries[readAddr].result};

	assign read  = commitReq & commitGrant;	// Retire on grant
	assign write = store;	// Decoder never stores while full

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < numEntry; i++) begin
				entries[i].valid <= 1'b0;
				entries[i].done  <= 1'b0;
			end
		end else begin
			for (int i = 0; i < numEntry; i++) begin
				for (int p = 0; p < numPipe; p++) begin
					if (hit[p][i]) begin
						entries[i].done   <= 1'b1;
						entries[i].result <= comp[p].result;
					end
				end
			end
			if (read) begin	// Only the granted head is freed
				entries[readAddr].valid <= 1'b0;
				entries[readAddr].done  <= 1'b0;
			end
			if (write) begin
				entries[writeAddr].valid   <= 1'b1;
				entries[writeAddr].done    <= 1'b0;
				entries[writeAddr].issueNo <= storeNo;
			end
		end
	end

	ringBuffCtrl #(
		.numEntry  (numEntry)
	) ringCtrl (
		.clock     (clock),
		.reset     (reset),
		.write     (write),
		.read      (read),
		.writeAddr (writeAddr),
		.readAddr  (readAddr),
		.full      (full),
		.empty     (empty)
	);

	// Every pipe result lands in exactly one reserved slot
	for (genvar p = 0; p < numPipe; p++) begin : gHitCheck
		oneMatch: assert property (
			@(posedge clock) disable iff (reset) compValid[p] |-> $onehot(hit[p])
		);
	end

endmodule

//--- verif/commitTb.sv
module commitTb;

	localparam int numEntry     = 16;
	localparam int numTestInstr = 4 + 3 + 3 + (numEntry + 1) + 40;
	localparam int timeoutCycle = numTestInstr * 40;

	logic                clock;
	logic                reset;
	logic                instrValid;
	robPkg::instrS       instr;
	logic                instrStall;
	logic                commitGrant;
	logic                commitReq;
	robPkg::commitS      commit;
	logic                full;
	logic                empty;

	robPkg::commitS expQ [$];	// Expected commits in issue order
	robPkg::issueNoT nextIssue;
	int             errors;
	int             checks;
	int             issued;
	int             committed;
	int             zeroCommits;	// Commits of issue 0, more than one once wrapped
	logic [31:0]    lcgState;
	logic           streamDone;

	commitTop #(.numEntry (numEntry)) dut_i (
		.clock (clock), .reset (reset),
		.instrValid (instrValid), .instr (instr), .instrStall (instrStall),
		.commitGrant (commitGrant), .commitReq (commitReq), .commit (commit),
		.full (full), .empty (empty)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Ends a hung run
	initial begin
		#(timeoutCycle * 10);
		$display("Timeout after %0d cycles, the commit stream stopped", timeoutCycle);
		$display("Simulation failed");
		$finish;
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, expected %0h, got %0h",
				$time, msg, expected, actual);
		end
	endtask

	// Holds the instruction until the decoder takes it
	task automatic sendInstr(input robPkg::opcodeT op, input robPkg::dataT a,
			input robPkg::dataT b);
		logic           accepted;
		robPkg::commitS exp;
		accepted   = 1'b0;
		instrValid = 1'b1;
		instr      = '{opcode: op, opA: a, opB: b};
		while (!accepted) begin
			@(negedge clock);
			accepted = !instrStall;
			@(posedge clock);
			#1;
		end
		exp.issueNo = nextIssue;
		exp.result  = (op == robPkg::opSub) ? robPkg::dataT'(a - b) : robPkg::dataT'(a + b);
		expQ.push_back(exp);
		nextIssue++;	// Wraps like the DUT counter
		issued++;
		instrValid = 1'b0;
	endtask

	task automatic sendRandom(input robPkg::opcodeT op);
		logic [31:0] r;
		logic [31:0] s;
		r = nextRand();
		s = nextRand();
		sendInstr(op, r[31:16], s[31:16]);
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0) begin
			@(posedge clock);
		end
		@(negedge clock);
		checkEq(empty, 1'b1, "empty after drain");
		@(posedge clock);
		#1;
	endtask

	// Commit monitor sampled away from the active edge
	always @(negedge clock) begin
		if (!reset && commitReq && commitGrant) begin
			if (expQ.size() == 0) begin
				errors++;
				$display("Commit of issue %0d at %0t with no instruction outstanding",
					commit.issueNo, $time);
			end else begin
				checkEq(commit.issueNo, expQ[0].issueNo, "commit issue number");
				checkEq(commit.result, expQ[0].result, "commit result");
				if (commit.issueNo == '0) begin
					zeroCommits++;
				end
				void'(expQ.pop_front());
				committed++;
			end
		end
	end

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic testReset();
		checkEq(empty, 1'b1, "empty after reset");
		checkEq(full, 1'b0, "full after reset");
		checkEq(commitReq, 1'b0, "commitReq after reset");
		checkEq(instrStall, 1'b0, "instrStall after reset");
	endtask

	task automatic testEachOpcode();
		commitGrant = 1'b1;
		for (int op = 0; op < 4; op++) begin
			sendRandom(robPkg::opcodeT'(op));
			waitDrain();
		end
	endtask

	task automatic testOutOfOrder();
		commitGrant = 1'b1;
		sendRandom(robPkg::opAdd);	// Slow pipe first
		sendRandom(robPkg::opLoad);
		sendRandom(robPkg::opLoad);
		waitDrain();
	endtask

	task automatic testGrantHeld();
		robPkg::issueNoT headNo;
		commitGrant = 1'b0;
		sendRandom(robPkg::opSub);
		sendRandom(robPkg::opStore);
		sendRandom(robPkg::opLoad);
		while (!commitReq) begin
			@(negedge clock);
		end
		headNo = expQ[0].issueNo;
		repeat (8) begin
			@(negedge clock);
			checkEq(commitReq, 1'b1, "commitReq held without grant");
			checkEq(commit.issueNo, headNo, "head stays without grant");
			checkEq(expQ.size(), 3, "entries kept without grant");
		end
		@(posedge clock);
		#1;
		commitGrant = 1'b1;
		waitDrain();
	endtask

	task automatic testFull();
		int committedBefore;
		int commitsAtTake;
		commitGrant = 1'b0;
		repeat (numEntry) begin
			sendRandom(robPkg::opAdd);
		end
		committedBefore = committed;
		commitsAtTake   = 0;
		fork
			begin
				sendRandom(robPkg::opStore);	// Extra one held while stalled
				commitsAtTake = committed - committedBefore;
			end
			begin
				repeat (6) begin
					@(negedge clock);
					checkEq(full, 1'b1, "full with numEntry outstanding");
					checkEq(instrStall, 1'b1, "instrStall while full");
					checkEq(expQ.size(), numEntry, "extra not taken while full");
				end
				while (!commitReq) begin
					@(negedge clock);
				end
				@(posedge clock);
				#1;
				commitGrant = 1'b1;	// Exactly one commit
				@(posedge clock);
				#1;
				commitGrant = 1'b0;
			end
		join
		checkEq(commitsAtTake, 1, "extra taken after exactly one commit");
		commitGrant = 1'b1;
		waitDrain();
	endtask

	task automatic testRandomStream();
		logic [31:0] r;
		streamDone = 1'b0;
		fork
			begin
				for (int n = 0; n < 40; n++) begin
					r = nextRand();
					sendRandom(robPkg::opcodeT'(r[17:16]));
				end
				streamDone = 1'b1;
			end
			while (!streamDone) begin
				@(posedge clock);
				#1;
				commitGrant = ~commitGrant;
			end
		join
		commitGrant = 1'b1;
		waitDrain();
		checkEq(zeroCommits >= 2, 1'b1, "issue numbers wrapped past 63");
	endtask

	initial begin
		reset       = 1'b1;
		instrValid  = 1'b0;
		instr       = '0;
		commitGrant = 1'b0;
		nextIssue   = '0;
		errors      = 0;
		checks      = 0;
		issued      = 0;
		committed   = 0;
		zeroCommits = 0;
		lcgState    = 32'd10709;
		streamDone  = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		testReset();
		testEachOpcode();
		testOutOfOrder();
		testGrantHeld();
		testFull();
		testRandomStream();
		checkEq(committed, issued, "every issued instruction committed");

		$display("Checks: %0d, errors: %0d, issued: %0d, committed: %0d",
			checks, errors, issued, committed);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
